//--- dv/mem_input.hex
// memory image words 0..63, eight per line, then the frame count,
// then one frame per line: address  write_flag  write_data
05001234 03000020 02000030 00000000 04000008 05000bad 05000bad 05000bad
01000021 03000022 02000031 01000030 03000031 02000032 0400000e 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
11223344 a1b2c3d4 7f6e5d4c 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
5a5a5a5a a5a5a5a5 0f0f0f0f 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// frame count
00000017
// expected frames
00000000 0 00000000  // idle frame before the first step
00000000 0 00000000  // boot fetch
00000001 0 00000000  // after ldi, no execute frame
00000020 0 00000000
00000002 0 00000000
00000030 1 11224578  // 1234 + 11223344
00000003 0 00000000
00000004 0 00000000  // no-op falls through
00000008 0 00000000  // jump target
00000021 0 00000000
00000009 0 00000000
00000022 0 00000000
0000000a 0 00000000
00000031 1 21212120  // a1b2c3d4 + 7f6e5d4c wraps
0000000b 0 00000000
00000030 0 00000000  // reads back the first store
0000000c 0 00000000
00000031 0 00000000
0000000d 0 00000000
00000032 1 32436698
0000000e 0 00000000
0000000e 0 00000000  // jump to itself
0000000e 0 00000000

//--- dv/tb_cpu_pin_handler.sv
// testbench for the cpu pin handler
// memory model on the pins, every frame checked against the expected trace
`timescale 1ns/10ps
`include "bus_bridge_cfg.svh"

module tb_cpu_pin_handler;

  localparam int MEM_WORDS  = 64;
  localparam int MAX_FRAMES = 64;
  localparam int PH         = `BB_FRAME_PHASES;
  localparam int B          = `BB_BYTE_W;
  localparam int READ_FIRST = PH - 4;  // four read bytes close the frame

  logic         clk;
  logic         arst_n;
  logic [B-1:0] uio_in;
  logic [B-1:0] uo_out;
  logic [B-1:0] uio_out;
  logic [B-1:0] uio_oe;

  logic [31:0] file_words [0:MEM_WORDS+1+3*MAX_FRAMES-1];
  logic [31:0] mem [0:MEM_WORDS-1];      // memory model
  logic [31:0] exp_mem [0:MEM_WORDS-1];  // image after the trace writes
  logic [31:0] exp_addr [0:MAX_FRAMES-1];
  logic [31:0] exp_data [0:MAX_FRAMES-1];
  logic        exp_w [0:MAX_FRAMES-1];

  logic [31:0] cur_addr;  // decoded from uo_out, low byte first
  logic [31:0] cur_data;
  logic        got_w;
  int num_frames   = 0;
  int frames_done  = 0;
  int edge_cnt     = 0;  // rising edges with arst_n high
  int cycle_cnt    = 0;
  int cycle_limit  = 0;
  int value_errors = 0;
  int other_errors = 0;

  cpu_pin_handler dut0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (arst_n) edge_cnt <= edge_cnt + 1;
  end

  task automatic fail_value(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    value_errors++;
  endtask

  task automatic finish_run();
    $display("error counts: %0d value mismatches, %0d other errors",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  // image, frame count, then address / write flag / data per frame
  task automatic load_stimulus(output bit ok);
    $readmemh("dv/mem_input.hex", file_words);
    num_frames = file_words[MEM_WORDS];
    ok = (num_frames >= 1 && num_frames <= MAX_FRAMES);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = file_words[i];
      exp_mem[i] = file_words[i];
    end
    for (int f = 0; f < num_frames && ok; f++) begin
      exp_addr[f] = file_words[MEM_WORDS+1+3*f];
      exp_w[f]    = file_words[MEM_WORDS+2+3*f][0];
      exp_data[f] = file_words[MEM_WORDS+3+3*f];
      if (exp_w[f] && exp_addr[f] < MEM_WORDS) exp_mem[exp_addr[f]] = exp_data[f];
    end
  endtask

  task automatic check_idle_pins(input string when);
    if (uo_out !== '0) fail_value($sformatf("%s: uo_out %h not zero", when, uo_out));
    if (uio_out !== '0) fail_value($sformatf("%s: uio_out %h not zero", when, uio_out));
    if (uio_oe !== '0) fail_value($sformatf("%s: uio_oe %h not zero", when, uio_oe));
  endtask

  task automatic check_frame(input int n);
    if (cur_addr !== exp_addr[n])
      fail_value($sformatf("frame %0d address %h expected %h", n, cur_addr, exp_addr[n]));
    if (got_w !== exp_w[n])
      fail_value($sformatf("frame %0d write flag %b expected %b", n, got_w, exp_w[n]));
    if (exp_w[n] && cur_data !== exp_data[n])
      fail_value($sformatf("frame %0d write data %h expected %h", n, cur_data, exp_data[n]));
  endtask

  // pin value of frame n, phase k
  task automatic sample_pins(input int n, input int k);
    logic [B-1:0] exp_oe;
    exp_oe = (k == 0) ? ((n == 0) ? '0 : {B{exp_w[n-1]}}) : {B{exp_w[n]}};
    if (uio_oe !== exp_oe)
      fail_value($sformatf("frame %0d phase %0d uio_oe %h expected %h", n, k, uio_oe, exp_oe));
    if (k == 0 || k >= READ_FIRST) begin
      if (uo_out !== '0) fail_value($sformatf("frame %0d phase %0d uo_out %h", n, k, uo_out));
      if (uio_out !== '0) fail_value($sformatf("frame %0d phase %0d uio_out %h", n, k, uio_out));
      if (k == PH - 1) frames_done = n + 1;
    end else if (k <= 4) begin
      cur_addr[B*(k-1) +: B] = uo_out;
      cur_data[B*(k-1) +: B] = uio_out;
      if (!exp_w[n] && uio_out !== '0)
        fail_value($sformatf("read frame %0d phase %0d uio_out %h", n, k, uio_out));
    end else begin
      got_w = uo_out[0];
      if (uo_out[B-1:1] !== '0) fail_value($sformatf("frame %0d flag byte %h", n, uo_out));
      if (uio_out !== '0) fail_value($sformatf("frame %0d phase 5 uio_out %h", n, uio_out));
      check_frame(n);
      if (got_w === 1'b1) begin
        if (cur_addr < MEM_WORDS) begin
          mem[cur_addr] = cur_data;
        end else begin
          $display("frame %0d writes address %h outside the memory model", n, cur_addr);
          other_errors++;
        end
      end
    end
  endtask

  // read byte for the phase that just started, msb first
  task automatic drive_read(input int e);
    int kd;
    kd = e % PH;
    if (kd >= READ_FIRST && cur_addr < MEM_WORDS) begin
      uio_in = mem[cur_addr][B*(PH-1-kd) +: B];
    end else begin
      uio_in = '0;
      if (kd == READ_FIRST) begin
        $display("read of address %h outside the memory model", cur_addr);
        other_errors++;
      end
    end
  endtask

  task automatic check_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (mem[i] !== exp_mem[i])
        fail_value($sformatf("memory word %0d holds %h expected %h", i, mem[i], exp_mem[i]));
    end
  endtask

  initial begin
    bit ok;
    int t;
    arst_n = 1'b0;
    uio_in = '0;
    load_stimulus(ok);
    if (!ok) begin
      $display("stimulus file missing or frame count %0d not usable", num_frames);
      other_errors++;
      finish_run();
    end else begin
      cycle_limit = PH * (num_frames + 2);
      repeat (4) begin
        @(negedge clk);
        check_idle_pins("reset");
      end
      arst_n = 1'b1;
      while (frames_done < num_frames) begin
        @(negedge clk);
        t = edge_cnt - 1;
        sample_pins(t / PH, t % PH);
        drive_read(edge_cnt);
      end
      check_memory();
      finish_run();
    end
  end

  initial begin
    wait (cycle_limit > 0);
    wait (cycle_cnt >= cycle_limit);
    $display("timeout after %0d cycles, %0d of %0d frames checked",
             cycle_cnt, frames_done, num_frames);
    other_errors++;
    finish_run();
  end

endmodule

//--- hdl/accum_cpu.sv
// accumulator processor
// issues one bus request per frame step and alternates fetch with execute
`timescale 1ns/10ps
`include "bus_bridge_cfg.svh"

module accum_cpu (
  input  logic   clk,
  input  logic   arst_n,
  cpu_bus_if.cpu bus
);
  import cpu_bus_pkg::*;

  cpu_state_t state;
  cpu_addr_t  pc;       // address of the current instruction
  cpu_word_t  acc;
  cpu_word_t  instr;
  cpu_addr_t  req_addr;
  cpu_word_t  req_wdata;
  logic       req_write;

  opcode_t    new_op;   // word just fetched
  opcode_t    cur_op;   // instruction waiting on its execute frame
  cpu_addr_t  operand;
  cpu_addr_t  pc_next;

  assign new_op  = opcode_t'(bus.rdata[`BB_WORD_W-1:OPC_LSB]);
  assign cur_op  = opcode_t'(instr[`BB_WORD_W-1:OPC_LSB]);
  assign operand = cpu_addr_t'(bus.rdata[OPERAND_W-1:0]);
  assign pc_next = pc + 1'b1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= BOOT;
      pc        <= '0;
      acc       <= '0;
      req_addr  <= '0;
      req_write <= 1'b0;
    end else if (bus.step) begin
      req_write <= 1'b0;  // everything but STA reads
      case (state)
        BOOT: begin
          // nothing valid on rdata yet
          req_addr <= '0;
          state    <= FETCH;
        end
        FETCH: begin
          case (new_op)
            LDA, ADD: begin
              req_addr <= operand;
              state    <= EXEC;
            end
            STA: begin
              req_addr  <= operand;
              req_write <= 1'b1;
              state     <= EXEC;
            end
            JMP: begin
              pc       <= operand;
              req_addr <= operand;  // target is the next fetch
            end
            LDI: begin
              acc      <= cpu_word_t'(bus.rdata[OPERAND_W-1:0]);
              pc       <= pc_next;
              req_addr <= pc_next;
            end
            default: begin  // no-op
              pc       <= pc_next;
              req_addr <= pc_next;
            end
          endcase
        end
        EXEC: begin
          if (cur_op == LDA) begin
            acc <= bus.rdata;
          end else if (cur_op == ADD) begin
            acc <= acc + bus.rdata;  // wraps mod 2^32
          end
          pc       <= pc_next;
          req_addr <= pc_next;
          state    <= FETCH;
        end
        default: state <= BOOT;
      endcase
    end
  end

  // instruction and store data
  always_ff @(posedge clk) begin
    if (bus.step && state == FETCH) begin
      instr <= bus.rdata;
      if (new_op == STA) begin
        req_wdata <= acc;
      end
    end
  end

  assign bus.addr  = req_addr;
  assign bus.wdata = req_wdata;
  assign bus.write = req_write;

endmodule

//--- hdl/cpu_bus_if.sv
// processor bus between the accumulator core and the pin bridge
// one request per frame step plus the assembled read word
`timescale 1ns/10ps

interface cpu_bus_if;
  import cpu_bus_pkg::*;

  cpu_addr_t addr;   // request address, held until next step
  cpu_word_t wdata;
  logic      write;
  logic      step;   // one cycle per frame
  cpu_word_t rdata;  // read word of the frame just finished

  modport cpu (
    output addr,
    output wdata,
    output write,
    input  step,
    input  rdata
  );

  modport bridge (
    input  write,
    output step
  );

  modport capture (
    output rdata
  );

endinterface

//--- hdl/cpu_bus_pkg.sv
// processor bus package
// word, address, opcode, processor state and frame phase types
`include "bus_bridge_cfg.svh"

package cpu_bus_pkg;

  typedef logic [`BB_WORD_W-1:0] cpu_word_t;
  typedef logic [`BB_WORD_W-1:0] cpu_addr_t;  // word address, not byte

  // instruction layout: opcode on top, operand below
  localparam int OPC_LSB   = 24;
  localparam int OPERAND_W = 24;

  typedef enum logic [7:0] {
    LDA = 8'h01,  // acc = mem[operand]
    STA = 8'h02,  // mem[operand] = acc
    ADD = 8'h03,  // acc += mem[operand]
    JMP = 8'h04,
    LDI = 8'h05   // acc = operand, zero extended
  } opcode_t;

  typedef enum logic [1:0] {
    BOOT,
    FETCH,
    EXEC
  } cpu_state_t;

  typedef logic [3:0] phase_t;

  // fixed positions inside the frame
  localparam phase_t PH_ADDR_FIRST = 4'd1;
  localparam phase_t PH_ADDR_LAST  = 4'd4;
  localparam phase_t PH_WFLAG      = 4'd5;
  localparam phase_t PH_READ_FIRST = 4'd6;

endpackage

//--- hdl/cpu_pin_handler.sv
// cpu pin handler, top level
// accumulator core behind an 8-bit pin bus, one ten-phase frame per request
`timescale 1ns/10ps
`include "bus_bridge_cfg.svh"

module cpu_pin_handler (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`BB_BYTE_W-1:0] uio_in,
  output logic [`BB_BYTE_W-1:0] uo_out,
  output logic [`BB_BYTE_W-1:0] uio_out,
  output logic [`BB_BYTE_W-1:0] uio_oe
);
  import cpu_bus_pkg::*;

  logic                  ser_load;
  logic                  shift_en;
  logic                  cap_en;
  logic [`BB_BYTE_W-1:0] addr_byte;
  logic [`BB_BYTE_W-1:0] data_byte;

  cpu_bus_if bus ();

  accum_cpu u_cpu (
    .clk    (clk),
    .arst_n (arst_n),
    .bus    (bus.cpu)
  );

  frame_sequencer u_seq (
    .clk       (clk),
    .arst_n    (arst_n),
    .bus       (bus.bridge),
    .addr_byte (addr_byte),
    .data_byte (data_byte),
    .ser_load  (ser_load),
    .shift_en  (shift_en),
    .cap_en    (cap_en),
    .uo_out    (uo_out),
    .uio_out   (uio_out),
    .uio_oe    (uio_oe)
  );

  // address bytes on uo_out
  word_serializer #(.payload_t(cpu_addr_t)) addr_ser (
    .clk      (clk),
    .arst_n   (arst_n),
    .load     (ser_load),
    .value    (bus.addr),
    .shift_en (shift_en),
    .byte_out (addr_byte)
  );

  // write data on uio_out
  word_serializer #(.payload_t(cpu_word_t)) data_ser (
    .clk      (clk),
    .arst_n   (arst_n),
    .load     (ser_load),
    .value    (bus.wdata),
    .shift_en (shift_en),
    .byte_out (data_byte)
  );

  read_assembler u_rd_asm (
    .clk      (clk),
    .arst_n   (arst_n),
    .cap_en   (cap_en),
    .pin_byte (uio_in),
    .bus      (bus.capture)
  );

endmodule

//--- hdl/frame_sequencer.sv
// frame sequencer
// phase counter, step/shift/capture strobes and the registered pin outputs
`timescale 1ns/10ps
`include "bus_bridge_cfg.svh"

module frame_sequencer (
  input  logic                  clk,
  input  logic                  arst_n,
  cpu_bus_if.bridge             bus,
  input  logic [`BB_BYTE_W-1:0] addr_byte,
  input  logic [`BB_BYTE_W-1:0] data_byte,
  output logic                  ser_load,
  output logic                  shift_en,
  output logic                  cap_en,
  output logic [`BB_BYTE_W-1:0] uo_out,
  output logic [`BB_BYTE_W-1:0] uio_out,
  output logic [`BB_BYTE_W-1:0] uio_oe
);
  import cpu_bus_pkg::*;

  localparam phase_t LAST_PHASE = phase_t'(`BB_FRAME_PHASES - 1);

  phase_t phase;
  logic   step;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase    <= '0;
      step     <= 1'b0;
      ser_load <= 1'b0;
    end else begin
      if (phase == LAST_PHASE) begin
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
      step     <= (phase == LAST_PHASE);  // high while phase is 0
      ser_load <= step;                   // new request reaches the serializers
    end
  end

  assign bus.step = step;
  assign shift_en = (phase >= PH_ADDR_FIRST) && (phase <= PH_ADDR_LAST);
  assign cap_en   = (phase >= PH_READ_FIRST);

  // byte for phase k shows up on the edge that ends phase k
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uo_out  <= '0;
      uio_out <= '0;
      uio_oe  <= '0;
    end else begin
      uo_out  <= '0;
      uio_out <= '0;
      if (shift_en) begin
        uo_out  <= addr_byte;
        uio_out <= bus.write ? data_byte : '0;
      end else if (phase == PH_WFLAG) begin
        uo_out <= {{(`BB_BYTE_W-1){1'b0}}, bus.write};
      end
      // drive uio for the whole frame of a write
      if (phase == PH_ADDR_FIRST) begin
        uio_oe <= {`BB_BYTE_W{bus.write}};
      end
    end
  end

endmodule

//--- hdl/read_assembler.sv
// read assembler
// gathers four pin bytes into the read word, first byte ends up on top
`timescale 1ns/10ps
`include "bus_bridge_cfg.svh"

module read_assembler (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  cap_en,
  input  logic [`BB_BYTE_W-1:0] pin_byte,
  cpu_bus_if.capture            bus
);

  localparam int W = `BB_WORD_W;
  localparam int B = `BB_BYTE_W;

  logic [W-1:0] word_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      word_q <= '0;
    end else if (cap_en) begin
      word_q <= {word_q[W-B-1:0], pin_byte};  // msb first
    end
  end

  // complete during phase 0, when the step takes it
  assign bus.rdata = word_q;

endmodule

//--- hdl/word_serializer.sv
// word serializer
// sends a loaded word out one byte per strobe, low byte first
`timescale 1ns/10ps
`include "bus_bridge_cfg.svh"

module word_serializer #(
  parameter type payload_t = cpu_bus_pkg::cpu_word_t
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  load,
  input  payload_t              value,
  input  logic                  shift_en,
  output logic [`BB_BYTE_W-1:0] byte_out
);

  localparam int W = $bits(payload_t);
  localparam int B = `BB_BYTE_W;

  logic [W-1:0] value_bits;
  logic [W-1:0] shreg;

  assign value_bits = value;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shreg <= '0;
    end else if (load) begin
      // low byte goes out in the load cycle itself
      shreg <= shift_en ? (value_bits >> B) : value_bits;
    end else if (shift_en) begin
      shreg <= shreg >> B;
    end
  end

  // bypass on load so the first byte is not a cycle late
  assign byte_out = load ? value_bits[B-1:0] : shreg[B-1:0];

endmodule

//--- include/bus_bridge_cfg.svh
// bus bridge configuration
// frame length and the byte and word widths shared by the bridge blocks
`ifndef BUS_BRIDGE_CFG_SVH
`define BUS_BRIDGE_CFG_SVH

// phases in one bus frame
// step, 4 address bytes, write flag, 4 read bytes
`define BB_FRAME_PHASES 10

// width of the pin bytes
`define BB_BYTE_W 8

// processor word width, four pin bytes
`define BB_WORD_W 32

`endif

//--- project.f
+incdir+include
hdl/cpu_bus_pkg.sv
hdl/cpu_bus_if.sv
hdl/accum_cpu.sv
hdl/frame_sequencer.sv
hdl/word_serializer.sv
hdl/read_assembler.sv
hdl/cpu_pin_handler.sv
dv/tb_cpu_pin_handler.sv
